//--- Bender.yml
package:
  name: game_char

sources:
  - include_dirs:
      - .
    files:
      - game_pkg.sv
      - frame_timer.sv
      - key_decode.sv
      - char_ctrl.sv
      - char_sprite.sv
      - game_char_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - game_char_checker.sv
      - game_char_tb.sv

//--- char_ctrl.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module char_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  frame_tick,
    input  game_pkg::move_cmd_e   move_cmd,
    input  logic                  jump_held,
    input  logic                  mouse_left,
    output logic [11:0]           pos_x,
    output logic [11:0]           pos_y,
    output game_pkg::char_state_e char_state,
    output logic                  flip_h,
    output logic                  draw_weapon
);

    import game_pkg::*;

    localparam logic [11:0] START_X  = 12'(`HOR_CENTER);
    localparam logic [11:0] GROUND   = 12'(`GROUND_Y);
    localparam logic [11:0] STEP     = 12'(`MOVE_STEP);
    localparam logic [11:0] RISE_STP = 12'(`JUMP_SPEED);
    localparam logic [11:0] FALL_STP = 12'(`FALL_SPEED);

    // horizontal margins, one step inside the edge.
    localparam logic [11:0] LEFT_LIM  = 12'(`CHAR_WID + `MOVE_STEP);
    localparam logic [11:0] RIGHT_LIM = 12'(`HOR_PIXELS - `CHAR_WID - `MOVE_STEP);

    // vertical turn points.
    localparam logic [11:0] PEAK_LIM = 12'(`GROUND_Y - `JUMP_HEIGHT + `JUMP_SPEED);
    localparam logic [11:0] LAND_LIM = 12'(`GROUND_Y - `FALL_SPEED);

    // ====================
    // horizontal motion
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_x <= START_X;
        end else if (frame_tick) begin
            case (move_cmd)
                MOVE_LEFT: begin
                    if (pos_x > LEFT_LIM) begin
                        pos_x <= pos_x - STEP;
                    end
                end
                MOVE_RIGHT: begin
                    if (pos_x < RIGHT_LIM) begin
                        pos_x <= pos_x + STEP;
                    end
                end
                default: ;
            endcase
        end
    end

    // ====================
    // jump FSM
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pos_y      <= GROUND;
            char_state <= ST_GROUND;
        end else if (frame_tick) begin
            case (char_state)
                ST_GROUND: begin
                    // takeoff costs one frame with no motion.
                    if (jump_held) begin
                        char_state <= ST_RISE;
                    end
                end
                ST_RISE: begin
                    if (pos_y > PEAK_LIM) begin
                        pos_y <= pos_y - RISE_STP;
                    end else begin
                        char_state <= ST_FALL;
                    end
                end
                ST_FALL: begin
                    if (pos_y < LAND_LIM) begin
                        pos_y <= pos_y + FALL_STP;
                    end else begin
                        pos_y      <= GROUND;
                        char_state <= ST_GROUND;
                    end
                end
                default: begin
                    char_state <= ST_GROUND;
                end
            endcase
        end
    end

    // ====================
    // facing and weapon
    // ====================

    // facing holds while idle.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip_h <= 1'b0;
        end else if (move_cmd == MOVE_LEFT) begin
            flip_h <= 1'b1;
        end else if (move_cmd == MOVE_RIGHT) begin
            flip_h <= 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            draw_weapon <= 1'b0;
        end else begin
            draw_weapon <= mouse_left;
        end
    end

endmodule

//--- char_sprite.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module char_sprite (
    input  logic        clk,
    input  logic        rst,
    input  logic [11:0] hcount,
    input  logic [11:0] vcount,
    input  logic [11:0] pos_x,
    input  logic [11:0] pos_y,
    input  logic        flip_h,
    input  logic        draw_weapon,
    output logic        pix_on,
    output logic [11:0] pix_rgb
);

    localparam logic [11:0] WID    = 12'(`CHAR_WID);
    localparam logic [11:0] HGT    = 12'(`CHAR_HGT);
    localparam logic [11:0] HEAD   = 12'(`HEAD_ROWS);
    localparam logic [11:0] W_ROW  = 12'(`WEAPON_ROW);
    localparam logic [11:0] W_ROWS = 12'(`WEAPON_ROWS);
    localparam logic [11:0] W_LEN  = 12'(`WEAPON_LEN);

    logic [11:0] dx;
    logic [11:0] dy;
    logic [11:0] dl;
    logic        in_box;
    logic        wpn_rows;
    logic        wpn_right;
    logic        wpn_left;
    logic        in_weapon;
    logic [11:0] rgb_nxt;

    // ====================
    // hit tests
    // ====================

    // offsets wrap when the scan point is above or left of the box.
    assign dx = hcount - pos_x;
    assign dy = vcount - pos_y;
    assign dl = pos_x - hcount;

    assign in_box    = (dx < WID) && (dy < HGT);
    assign wpn_rows  = (dy >= W_ROW) && (dy < W_ROW + W_ROWS);
    assign wpn_right = (dx >= WID) && (dx < WID + W_LEN);
    assign wpn_left  = (dl != 12'd0) && (dl <= W_LEN);
    assign in_weapon = draw_weapon && wpn_rows && (flip_h ? wpn_left : wpn_right);

    always_comb begin
        if (in_box) begin
            rgb_nxt = (dy < HEAD) ? `COL_SKIN : `COL_BODY;
        end else if (in_weapon) begin
            rgb_nxt = `COL_WEAPON;
        end else begin
            rgb_nxt = 12'h000;
        end
    end

    // ====================
    // output stage
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pix_on  <= 1'b0;
            pix_rgb <= 12'h000;
        end else begin
            pix_on  <= in_box || in_weapon;
            pix_rgb <= rgb_nxt;
        end
    end

endmodule

//--- frame_timer.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module frame_timer #(
    parameter int FRAME_TICKS = `FRAME_TICKS
) (
    input  logic clk,
    input  logic rst,
    output logic frame_tick
);

    localparam int CNT_W = $clog2(FRAME_TICKS);
    localparam logic [CNT_W-1:0] LAST = CNT_W'(FRAME_TICKS - 1);

    logic [CNT_W-1:0] tick_cnt;

    // one pulse per video frame.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick_cnt   <= '0;
            frame_tick <= 1'b0;
        end else if (tick_cnt == LAST) begin
            tick_cnt   <= '0;
            frame_tick <= 1'b1;
        end else begin
            tick_cnt   <= tick_cnt + 1'b1;
            frame_tick <= 1'b0;
        end
    end

endmodule

//--- game_char_checker.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module game_char_checker (
    input logic        clk,
    input logic        rst,
    input logic        frame_tick,
    input logic        mouse_left,
    input logic        draw_weapon,
    input logic [11:0] pos_x,
    input logic [11:0] pos_y
);

    localparam logic [11:0] TOP_Y   = 12'(`GROUND_Y - `JUMP_HEIGHT);
    localparam logic [11:0] MIN_X   = 12'(`CHAR_WID);
    localparam logic [11:0] MAX_X   = 12'(`HOR_PIXELS - `CHAR_WID);

    // ====================
    // motion limits
    // ====================

    a_jump_top: assert property (@(posedge clk) disable iff (rst) pos_y >= TOP_Y)
        else $error("pos_y %0d is above the jump peak", pos_y);

    a_margins: assert property (@(posedge clk) disable iff (rst)
        pos_x >= MIN_X && pos_x <= MAX_X)
        else $error("pos_x %0d is outside the screen margins", pos_x);

    // position moves only on a frame tick.
    a_hold: assert property (@(posedge clk) disable iff (rst)
        !frame_tick |=> $stable(pos_x) && $stable(pos_y))
        else $error("position changed without a frame tick");

    a_weapon: assert property (@(posedge clk) disable iff (rst)
        1'b1 |=> draw_weapon == $past(mouse_left))
        else $error("draw_weapon does not follow mouse_left");

endmodule

bind game_char_top game_char_checker i_game_char_checker (
    .clk         (clk),
    .rst         (rst),
    .frame_tick  (frame_tick),
    .mouse_left  (mouse_left),
    .draw_weapon (draw_weapon),
    .pos_x       (pos_x),
    .pos_y       (pos_y)
);

//--- game_char_tb.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module game_char_tb;

    import game_pkg::*;

    localparam int     FRAME_LEN  = 16;
    localparam int     RST_CYCLES = 16;
    localparam int     MAX_FRAMES = 800;
    localparam longint TIMEOUT_NS = longint'(RST_CYCLES + MAX_FRAMES * FRAME_LEN + 500) * 10;

    logic        clk = 1'b0;
    logic        rst;
    logic [7:0]  key_code;
    logic        key_valid;
    logic        key_release;
    logic        mouse_left;
    logic [11:0] hcount;
    logic [11:0] vcount;
    logic [11:0] pos_x;
    logic [11:0] pos_y;
    char_state_e char_state;
    logic        flip_h;
    logic        draw_weapon;
    logic        pix_on;
    logic [11:0] pix_rgb;

    // reference model state.
    int          m_x;
    int          m_y;
    char_state_e m_st;
    bit          m_left;
    bit          m_right;
    bit          m_jump;
    bit          m_flip;
    bit          m_wpn;

    int phase = 0;
    int ticks = 0;
    int frame_cnt = 0;
    int pos_errs = 0;
    int state_errs = 0;
    int bit_errs = 0;
    int rgb_errs = 0;

    game_char_top #(
        .FRAME_TICKS(FRAME_LEN)
    ) i_game_char_top (
        .clk         (clk),
        .rst         (rst),
        .key_code    (key_code),
        .key_valid   (key_valid),
        .key_release (key_release),
        .mouse_left  (mouse_left),
        .hcount      (hcount),
        .vcount      (vcount),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .char_state  (char_state),
        .flip_h      (flip_h),
        .draw_weapon (draw_weapon),
        .pix_on      (pix_on),
        .pix_rgb     (pix_rgb)
    );

    always #5 clk = ~clk;

    // ====================
    // reference model
    // ====================

    function automatic move_cmd_e model_move(bit left, bit right);
        if (left) begin
            return MOVE_LEFT;
        end else if (right) begin
            return MOVE_RIGHT;
        end
        return MOVE_IDLE;
    endfunction

    function automatic void step_frame(input move_cmd_e mv, input bit jump,
                                       inout int x, inout int y, inout char_state_e st);
        if (mv == MOVE_LEFT && x > `CHAR_WID + `MOVE_STEP) begin
            x -= `MOVE_STEP;
        end else if (mv == MOVE_RIGHT && x < `HOR_PIXELS - `CHAR_WID - `MOVE_STEP) begin
            x += `MOVE_STEP;
        end
        case (st)
            ST_GROUND: begin
                if (jump) begin
                    st = ST_RISE;
                end
            end
            ST_RISE: begin
                if (y > `GROUND_Y - `JUMP_HEIGHT + `JUMP_SPEED) begin
                    y -= `JUMP_SPEED;
                end else begin
                    st = ST_FALL;
                end
            end
            default: begin
                if (y < `GROUND_Y - `FALL_SPEED) begin
                    y += `FALL_SPEED;
                end else begin
                    y  = `GROUND_Y;
                    st = ST_GROUND;
                end
            end
        endcase
    endfunction

    // bit 12 holds the on flag and bits 11:0 the colour.
    function automatic logic [12:0] ref_pixel(int hx, int vy, int px, int py, bit flip, bit wpn);
        int cx;
        int ry;
        cx = hx - px;
        ry = vy - py;
        if (cx >= 0 && cx < `CHAR_WID && ry >= 0 && ry < `CHAR_HGT) begin
            return {1'b1, (ry < `HEAD_ROWS) ? `COL_SKIN : `COL_BODY};
        end
        if (wpn && ry >= `WEAPON_ROW && ry < `WEAPON_ROW + `WEAPON_ROWS) begin
            if (!flip && cx >= `CHAR_WID && cx < `CHAR_WID + `WEAPON_LEN) begin
                return {1'b1, `COL_WEAPON};
            end
            if (flip && cx < 0 && cx >= -(`WEAPON_LEN)) begin
                return {1'b1, `COL_WEAPON};
            end
        end
        return 13'd0;
    endfunction

    // ====================
    // compare tasks
    // ====================

    task automatic check_pos(string name, logic [11:0] exp, logic [11:0] act);
        if (act !== exp) begin
            pos_errs++;
            $display("Mismatch %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_state(string name, char_state_e exp, char_state_e act);
        if (act !== exp) begin
            state_errs++;
            $display("Mismatch %s: expected %s, actual %s (%0d)", name, exp.name(),
                     act.name(), act);
        end
    endtask

    task automatic check_bit(string name, logic exp, logic act);
        if (act !== exp) begin
            bit_errs++;
            $display("Mismatch %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_rgb(string name, logic [11:0] exp, logic [11:0] act);
        if (act !== exp) begin
            rgb_errs++;
            $display("Mismatch %s: expected %03h, actual %03h", name, exp, act);
        end
    endtask

    // mirrors the frame counter. frame_tick follows the wrap.
    always @(posedge clk or posedge rst) begin
        if (rst) begin
            phase <= 0;
            ticks <= 0;
        end else if (phase == FRAME_LEN - 1) begin
            phase <= 0;
            ticks <= ticks + 1;
        end else begin
            phase <= phase + 1;
        end
    end

    // model steps two cycles after each frame tick.
    always @(negedge clk) begin
        if (!rst && phase == 2 && ticks > frame_cnt) begin
            step_frame(model_move(m_left, m_right), m_jump, m_x, m_y, m_st);
            frame_cnt++;
            check_pos("frame pos_x", 12'(m_x), pos_x);
            check_pos("frame pos_y", 12'(m_y), pos_y);
            check_state("frame char_state", m_st, char_state);
            check_bit("frame flip_h", m_flip, flip_h);
        end
    end

    // ====================
    // stimulus helpers
    // ====================

    // key events go mid-frame, well clear of the tick.
    task automatic wait_slot();
        @(negedge clk);
        while (phase != 5) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic send_key(logic [7:0] code, bit brk);
        move_cmd_e mv;
        key_code    <= code;
        key_release <= brk;
        key_valid   <= 1'b1;
        if (code == KEY_LEFT) begin
            m_left = !brk;
        end else if (code == KEY_RIGHT) begin
            m_right = !brk;
        end else if (code == KEY_JUMP) begin
            m_jump = !brk;
        end
        mv = model_move(m_left, m_right);
        if (mv == MOVE_LEFT) begin
            m_flip = 1'b1;
        end else if (mv == MOVE_RIGHT) begin
            m_flip = 1'b0;
        end
        @(posedge clk);
        key_valid <= 1'b0;
    endtask

    task automatic wait_frames(int n);
        int target;
        target = frame_cnt + n;
        wait (frame_cnt >= target);
    endtask

    task automatic scan_pixel(int dx, int dy);
        logic [12:0] exp;
        hcount <= 12'(m_x + dx);
        vcount <= 12'(m_y + dy);
        @(posedge clk);
        @(negedge clk);
        exp = ref_pixel(m_x + dx, m_y + dy, m_x, m_y, m_flip, m_wpn);
        check_bit("sprite pix_on", exp[12], pix_on);
        check_rgb("sprite pix_rgb", exp[11:0], pix_rgb);
        @(posedge clk);
    endtask

    // ====================
    // test sequence
    // ====================

    initial begin
        bit         face;
        bit         wpn;
        logic [7:0] code;
        void'($urandom(47));
        rst         = 1'b1;
        key_code    = 8'h00;
        key_valid   = 1'b0;
        key_release = 1'b0;
        mouse_left  = 1'b1;
        // scan point inside the box while in reset.
        hcount      = 12'(`HOR_CENTER);
        vcount      = 12'(`GROUND_Y);
        m_x         = `HOR_CENTER;
        m_y         = `GROUND_Y;
        m_st        = ST_GROUND;
        m_left      = 1'b0;
        m_right     = 1'b0;
        m_jump      = 1'b0;
        m_flip      = 1'b0;
        m_wpn       = 1'b0;
        repeat (RST_CYCLES - 1) @(posedge clk);
        mouse_left <= 1'b0;
        @(negedge clk);
        check_pos("reset pos_x", 12'(`HOR_CENTER), pos_x);
        check_pos("reset pos_y", 12'(`GROUND_Y), pos_y);
        check_state("reset char_state", ST_GROUND, char_state);
        check_bit("reset flip_h", 1'b0, flip_h);
        check_bit("reset draw_weapon", 1'b0, draw_weapon);
        check_bit("reset pix_on", 1'b0, pix_on);
        check_rgb("reset pix_rgb", 12'h000, pix_rgb);
        @(posedge clk);
        rst <= 1'b0;

        // walk into both clamps, then both keys held.
        wait_slot();
        send_key(KEY_LEFT, 1'b0);
        wait_frames(100);
        wait_slot();
        send_key(KEY_LEFT, 1'b1);
        send_key(KEY_RIGHT, 1'b0);
        wait_frames(200);
        wait_slot();
        send_key(KEY_LEFT, 1'b0);
        wait_frames(4);
        wait_slot();
        send_key(KEY_LEFT, 1'b1);
        send_key(KEY_RIGHT, 1'b1);
        wait_frames(2);

        // full jump with a second press while rising.
        wait_slot();
        send_key(KEY_JUMP, 1'b0);
        wait_frames(3);
        wait_slot();
        send_key(KEY_JUMP, 1'b1);
        wait_frames(10);
        wait_slot();
        send_key(KEY_JUMP, 1'b0);
        wait_frames(2);
        wait_slot();
        send_key(KEY_JUMP, 1'b1);
        wait_frames(70);
        check_state("jump landed", ST_GROUND, char_state);

        wait_slot();
        mouse_left <= 1'b1;
        m_wpn = 1'b1;
        @(posedge clk);
        @(negedge clk);
        check_bit("draw_weapon on", 1'b1, draw_weapon);
        @(posedge clk);
        mouse_left <= 1'b0;
        m_wpn = 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_bit("draw_weapon off", 1'b0, draw_weapon);

        for (int i = 0; i < 6; i++) begin
            // every facing and weapon pair comes up once.
            face = (i < 4) ? i[0] : 1'($urandom % 2);
            wpn  = (i < 4) ? i[1] : 1'($urandom % 2);
            wait_slot();
            send_key(face ? KEY_LEFT : KEY_RIGHT, 1'b0);
            send_key(face ? KEY_LEFT : KEY_RIGHT, 1'b1);
            mouse_left <= wpn;
            m_wpn = wpn;
            @(posedge clk);
            repeat (40) scan_pixel(int'($urandom % 53) - 12, int'($urandom % 41) - 4);
            // strip ends on both sides.
            scan_pixel(-1, `WEAPON_ROW);
            scan_pixel(-(`WEAPON_LEN), `WEAPON_ROW + `WEAPON_ROWS - 1);
            scan_pixel(`CHAR_WID, `WEAPON_ROW);
            scan_pixel(`CHAR_WID + `WEAPON_LEN - 1, `WEAPON_ROW + `WEAPON_ROWS - 1);
        end

        // random make and break traffic, unknown bytes included.
        for (int i = 0; i < 150; i++) begin
            wait_slot();
            case ($urandom % 4)
                0: code = KEY_LEFT;
                1: code = KEY_RIGHT;
                2: code = KEY_JUMP;
                default: code = 8'($urandom);
            endcase
            send_key(code, 1'($urandom % 2));
        end
        wait_frames(2);

        $display("error counts: pos %0d, state %0d, bit %0d, rgb %0d",
                 pos_errs, state_errs, bit_errs, rgb_errs);
        if (pos_errs + state_errs + bit_errs + rgb_errs == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run timed out after %0d ns before the tests completed", TIMEOUT_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- game_char_top.f
+incdir+.
game_pkg.sv
frame_timer.sv
key_decode.sv
char_ctrl.sv
char_sprite.sv
game_char_top.sv
game_char_checker.sv
game_char_tb.sv

//--- game_char_top.sv
`timescale 1ns/1ns
`include "game_defines.svh"

module game_char_top #(
    parameter int FRAME_TICKS = `FRAME_TICKS
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [7:0]            key_code,
    input  logic                  key_valid,
    input  logic                  key_release,
    input  logic                  mouse_left,
    input  logic [11:0]           hcount,
    input  logic [11:0]           vcount,
    output logic [11:0]           pos_x,
    output logic [11:0]           pos_y,
    output game_pkg::char_state_e char_state,
    output logic                  flip_h,
    output logic                  draw_weapon,
    output logic                  pix_on,
    output logic [11:0]           pix_rgb
);

    import game_pkg::*;

    logic      frame_tick;
    move_cmd_e move_cmd;
    logic      jump_held;

    frame_timer #(
        .FRAME_TICKS(FRAME_TICKS)
    ) i_frame_timer (
        .clk        (clk),
        .rst        (rst),
        .frame_tick (frame_tick)
    );

    // raw byte, unknown codes included.
    key_decode i_key_decode (
        .clk         (clk),
        .rst         (rst),
        .key_code    (key_code_e'(key_code)),
        .key_valid   (key_valid),
        .key_release (key_release),
        .move_cmd    (move_cmd),
        .jump_held   (jump_held)
    );

    char_ctrl i_char_ctrl (
        .clk         (clk),
        .rst         (rst),
        .frame_tick  (frame_tick),
        .move_cmd    (move_cmd),
        .jump_held   (jump_held),
        .mouse_left  (mouse_left),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .char_state  (char_state),
        .flip_h      (flip_h),
        .draw_weapon (draw_weapon)
    );

    char_sprite i_char_sprite (
        .clk         (clk),
        .rst         (rst),
        .hcount      (hcount),
        .vcount      (vcount),
        .pos_x       (pos_x),
        .pos_y       (pos_y),
        .flip_h      (flip_h),
        .draw_weapon (draw_weapon),
        .pix_on      (pix_on),
        .pix_rgb     (pix_rgb)
    );

endmodule

//--- game_defines.svh
`ifndef GAME_DEFINES_SVH
`define GAME_DEFINES_SVH

// ====================
// screen
// ====================
`define HOR_PIXELS  1024
`define VER_PIXELS  768
`define HOR_CENTER  512

// ====================
// sprite geometry
// ====================
`define CHAR_WID    25
`define CHAR_HGT    32
// top row of the character when standing.
`define GROUND_Y    716
`define HEAD_ROWS   8
`define WEAPON_ROW  12
`define WEAPON_ROWS 4
`define WEAPON_LEN  8

// ====================
// motion
// ====================
`define JUMP_HEIGHT 200
`define JUMP_SPEED  7
`define FALL_SPEED  5
`define MOVE_STEP   5

// 60 frames per second at 65 MHz.
`define FRAME_TICKS 1_083_333

`define COL_SKIN    12'hFC9
`define COL_BODY    12'h24F
`define COL_WEAPON  12'hAAA

`endif

//--- game_pkg.sv
package game_pkg;

    // ====================
    // decode to execute
    // ====================

    // horizontal opcode.
    typedef enum logic [1:0] {
        MOVE_IDLE  = 2'd0,
        MOVE_LEFT  = 2'd1,
        MOVE_RIGHT = 2'd2
    } move_cmd_e;

    // keyboard scan codes of interest.
    typedef enum logic [7:0] {
        KEY_LEFT  = 8'h1C,
        KEY_RIGHT = 8'h23,
        KEY_JUMP  = 8'h1D
    } key_code_e;

    // ====================
    // character state
    // ====================

    typedef enum logic [1:0] {
        ST_GROUND = 2'd0,
        ST_RISE   = 2'd1,
        ST_FALL   = 2'd2
    } char_state_e;

endpackage

//--- key_decode.sv
`timescale 1ns/1ns

module key_decode (
    input  logic                clk,
    input  logic                rst,
    input  game_pkg::key_code_e key_code,
    input  logic                key_valid,
    input  logic                key_release,
    output game_pkg::move_cmd_e move_cmd,
    output logic                jump_held
);

    import game_pkg::*;

    logic      left_held;
    logic      right_held;
    logic      left_nxt;
    logic      right_nxt;
    logic      jump_nxt;
    move_cmd_e move_nxt;

    // ====================
    // held flags
    // ====================

    // make sets, break clears.
    always_comb begin
        left_nxt  = left_held;
        right_nxt = right_held;
        jump_nxt  = jump_held;
        if (key_valid) begin
            case (key_code)
                KEY_LEFT:  left_nxt  = !key_release;
                KEY_RIGHT: right_nxt = !key_release;
                KEY_JUMP:  jump_nxt  = !key_release;
                default:   ;
            endcase
        end
    end

    // left wins over right.
    always_comb begin
        if (left_nxt) begin
            move_nxt = MOVE_LEFT;
        end else if (right_nxt) begin
            move_nxt = MOVE_RIGHT;
        end else begin
            move_nxt = MOVE_IDLE;
        end
    end

    // ====================
    // registers
    // ====================

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            left_held  <= 1'b0;
            right_held <= 1'b0;
            jump_held  <= 1'b0;
            move_cmd   <= MOVE_IDLE;
        end else begin
            left_held  <= left_nxt;
            right_held <= right_nxt;
            jump_held  <= jump_nxt;
            move_cmd   <= move_nxt;
        end
    end

endmodule
